//--- include/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand width as seen by the issuing stage
`define MUL_WIDTH 32

// operand width after sign or zero extension
// two extra bits so unsigned operands stay positive in a signed Booth scheme
`define MUL_EXT_WIDTH 34

// radix-4 Booth rows, one per pair of extended multiplier bits
`define MUL_ROWS 17

// compressor columns, twice the operand width plus four
`define MUL_COLS 68

// bits per column: the Booth rows plus the correction row
`define MUL_COL_IN 18

// carries handed from one column to the next
`define MUL_COL_CARRY 15

`endif

//--- rtl/mulOpPkg.sv
package mulOpPkg;

    // operation select for the multiply unit
    // mulW   low word of the product
    // mulHW  high word, both operands signed
    // mulHWU high word, both operands unsigned
    typedef enum logic [1:0] {
        mulW   = 2'd0,
        mulHW  = 2'd1,
        mulHWU = 2'd2
    } mulOp_t;

endpackage

//--- rtl/mulArithPkg.sv
`include "mul_defines.svh"

package mulArithPkg;

    // one partial-product row, already shifted into its columns
    typedef logic [`MUL_COLS-1:0] ppRow_t;

    // Booth rows plus one correction row on top
    // the correction row holds the +1 of every negated row
    typedef ppRow_t [`MUL_COL_IN-1:0] ppArray_t;

    // carries leaving one compressor column for the next
    typedef logic [`MUL_COL_CARRY-1:0] colCarry_t;

endpackage

//--- rtl/boothEncoder.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module boothEncoder (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   inValid,
    input  mulOpPkg::mulOp_t       op,
    input  logic [`MUL_WIDTH-1:0]  multiplicand,
    input  logic [`MUL_WIDTH-1:0]  multiplier,
    output logic                   ppValid,
    output mulOpPkg::mulOp_t       ppOp,
    output mulArithPkg::ppArray_t  ppRows
);

    // sign bit feeding the extension, forced low for unsigned high word
    logic                      extSign;
    logic [`MUL_EXT_WIDTH-1:0] extA;
    logic [`MUL_EXT_WIDTH-1:0] extB;
    // multiplier with the implicit zero below bit 0
    logic [`MUL_EXT_WIDTH:0]   bPad;
    mulArithPkg::ppArray_t     rowsNext;

    assign extSign = (op != mulOpPkg::mulHWU);
    assign extA    = {{(`MUL_EXT_WIDTH-`MUL_WIDTH){extSign & multiplicand[`MUL_WIDTH-1]}},
                      multiplicand};
    assign extB    = {{(`MUL_EXT_WIDTH-`MUL_WIDTH){extSign & multiplier[`MUL_WIDTH-1]}},
                      multiplier};
    assign bPad    = {extB, 1'b0};

    always_comb begin
        logic [2:0]                grp;
        logic [`MUL_EXT_WIDTH:0]   mag;
        logic [`MUL_EXT_WIDTH:0]   sel;
        logic                      neg;
        mulArithPkg::ppRow_t       rowVal;

        rowsNext = '0;
        for (int i = 0; i < `MUL_ROWS; i++) begin
            grp = bPad[2*i +: 3];
            // magnitude of the digit times the multiplicand
            case (grp)
                3'b001, 3'b010, 3'b101, 3'b110: mag = {extA[`MUL_EXT_WIDTH-1], extA};
                3'b011, 3'b100:                 mag = {extA, 1'b0};
                default:                        mag = '0;
            endcase
            // 111 is a zero digit, not a negative one
            neg = grp[2] & ~(grp[1] & grp[0]);
            // ones complement here, the +1 lands in the correction row
            sel = neg ? ~mag : mag;
            rowVal = {{(`MUL_COLS-`MUL_EXT_WIDTH-1){sel[`MUL_EXT_WIDTH]}}, sel};
            rowsNext[i] = rowVal << (2*i);
            rowsNext[`MUL_ROWS][2*i] = neg;
        end
    end

    // first pipeline register
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ppValid <= 1'b0;
            ppOp    <= mulOpPkg::mulW;
            ppRows  <= '0;
        end else begin
            ppValid <= inValid;
            // payload only moves with a real request
            if (inValid) begin
                ppOp   <= op;
                ppRows <= rowsNext;
            end
        end
    end

endmodule

//--- rtl/wallaceColumn.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module wallaceColumn (
    input  logic [`MUL_COL_IN-1:0] colIn,
    input  mulArithPkg::colCarry_t carryIn,
    output mulArithPkg::colCarry_t carryOut,
    output logic                   sumBit,
    output logic                   carryBit
);

    // one adder per outgoing carry plus the last one for the outputs
    localparam int faCount = `MUL_COL_CARRY + 1;

    // node pool: column bits, incoming carries, then inner sums
    // adder i eats nodes 3i..3i+2, each inner sum is read by a later adder
    logic [3*faCount-1:0] node;
    logic [faCount-1:0]   faSum;
    logic [faCount-1:0]   faCarry;

    assign node[`MUL_COL_IN-1:0]                         = colIn;
    assign node[`MUL_COL_IN +: `MUL_COL_CARRY]           = carryIn;
    assign node[`MUL_COL_IN+`MUL_COL_CARRY +: faCount-1] = faSum[faCount-2:0];

    genvar i;
    generate
        for (i = 0; i < faCount; i++) begin : gFa
            logic a;
            logic b;
            logic c;

            assign a = node[3*i];
            assign b = node[3*i+1];
            assign c = node[3*i+2];
            // plain full adder cell
            assign faSum[i]   = a ^ b ^ c;
            assign faCarry[i] = (a & b) | (b & c) | (a & c);
        end
    endgenerate

    // every carry but the last one moves to the next column
    assign carryOut = faCarry[faCount-2:0];

    // last adder leaves the column's two bits for the final add
    assign sumBit   = faSum[faCount-1];
    assign carryBit = faCarry[faCount-1];

endmodule

//--- rtl/productStage.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module productStage (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   ppValid,
    input  mulOpPkg::mulOp_t       ppOp,
    input  mulArithPkg::ppArray_t  ppRows,
    output logic                   outValid,
    output logic [`MUL_WIDTH-1:0]  product
);

    // entry k feeds column k, the top entry holds carries past the last column
    mulArithPkg::colCarry_t colCarry [`MUL_COLS+1];
    logic [`MUL_COLS-1:0]   sumVec;
    logic [`MUL_COLS-1:0]   carryVec;
    logic [2*`MUL_WIDTH-1:0] fullProd;
    logic [`MUL_WIDTH-1:0]  prodWord;

    // column 0 has nothing coming in from below
    assign colCarry[0] = '0;

    genvar k;
    genvar r;
    generate
        for (k = 0; k < `MUL_COLS; k++) begin : gCol
            logic [`MUL_COL_IN-1:0] colBits;

            // bit k of every row, correction row included
            for (r = 0; r < `MUL_COL_IN; r++) begin : gBit
                assign colBits[r] = ppRows[r][k];
            end

            wallaceColumn colInst (
                .colIn    (colBits),
                .carryIn  (colCarry[k]),
                .carryOut (colCarry[k+1]),
                .sumBit   (sumVec[k]),
                .carryBit (carryVec[k])
            );
        end
    endgenerate

    // carry-propagate add, column carries weigh one column more
    assign fullProd = sumVec[2*`MUL_WIDTH-1:0]
                    + {carryVec[2*`MUL_WIDTH-2:0], 1'b0};

    // both high-word ops read the same half
    // signedness was settled at operand extension
    assign prodWord = (ppOp == mulOpPkg::mulW) ? fullProd[`MUL_WIDTH-1:0]
                                               : fullProd[2*`MUL_WIDTH-1:`MUL_WIDTH];

    // output register
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            product  <= '0;
        end else begin
            outValid <= ppValid;
            if (ppValid) begin
                product <= prodWord;
            end
        end
    end

endmodule

//--- rtl/mulUnit.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mulUnit (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  mulOpPkg::mulOp_t      op,
    input  logic [`MUL_WIDTH-1:0] multiplicand,
    input  logic [`MUL_WIDTH-1:0] multiplier,
    output logic                  outValid,
    output logic [`MUL_WIDTH-1:0] product
);

    // stage 1 to stage 2
    logic                  ppValid;
    mulOpPkg::mulOp_t      ppOp;
    mulArithPkg::ppArray_t ppRows;

    // extension, Booth rows, first register
    boothEncoder boothEncoder_inst (
        .Clk          (Clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .op           (op),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ppValid      (ppValid),
        .ppOp         (ppOp),
        .ppRows       (ppRows)
    );

    // column compression, final add, word select, second register
    productStage productStage_inst (
        .Clk      (Clk),
        .rstN     (rstN),
        .ppValid  (ppValid),
        .ppOp     (ppOp),
        .ppRows   (ppRows),
        .outValid (outValid),
        .product  (product)
    );

endmodule

//--- bench/mulUnitTb.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mulUnitTb;

    localparam int resetCycles = 10;
    localparam int tableLen    = 16;
    localparam int randCount   = 64;

    logic                  Clk;
    logic                  rstN;
    logic                  inValid;
    mulOpPkg::mulOp_t      op;
    logic [`MUL_WIDTH-1:0] multiplicand;
    logic [`MUL_WIDTH-1:0] multiplier;
    logic                  outValid;
    logic [`MUL_WIDTH-1:0] product;

    // stimulus table, one row per directed case
    string                 tabName [tableLen];
    mulOpPkg::mulOp_t      tabOp   [tableLen];
    logic [`MUL_WIDTH-1:0] tabA    [tableLen];
    logic [`MUL_WIDTH-1:0] tabB    [tableLen];
    // idle cycles inserted after the entry
    int                    tabGap  [tableLen];

    // requests in flight, oldest first
    logic [`MUL_WIDTH-1:0] expQ [$];
    string                 nameQ [$];
    int                    dueQ [$];

    int     cycle = 0;
    int     timeoutLimit;
    integer seed;

    mulUnit mulUnit_inst (
        .Clk          (Clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .op           (op),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .outValid     (outValid),
        .product      (product)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle <= cycle + 1;
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // reference result straight from the 64-bit product
    function automatic logic [`MUL_WIDTH-1:0] expectedWord(input mulOpPkg::mulOp_t o,
                                                           input logic [31:0] a,
                                                           input logic [31:0] b);
        logic signed [63:0] sProd;
        logic [63:0]        uProd;
        sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uProd = {32'd0, a} * {32'd0, b};
        case (o)
            mulOpPkg::mulW:  return sProd[31:0];
            mulOpPkg::mulHW: return sProd[63:32];
            default:         return uProd[63:32];
        endcase
    endfunction

    function automatic mulOpPkg::mulOp_t opFromIndex(input int idx);
        case (idx)
            0:       return mulOpPkg::mulW;
            1:       return mulOpPkg::mulHW;
            default: return mulOpPkg::mulHWU;
        endcase
    endfunction

    task automatic setEntry(input int idx, input string name, input mulOpPkg::mulOp_t o,
                            input logic [31:0] a, input logic [31:0] b, input int gap);
        tabName[idx] = name;
        tabOp[idx]   = o;
        tabA[idx]    = a;
        tabB[idx]    = b;
        tabGap[idx]  = gap;
    endtask

    task automatic loadTable();
        setEntry(0,  "mulW small",          mulOpPkg::mulW,   32'd7,        32'd6,        0);
        setEntry(1,  "mulW neg x pos",      mulOpPkg::mulW,   32'hfffffffb, 32'h00000003, 0);
        setEntry(2,  "mulW neg x neg",      mulOpPkg::mulW,   32'hfffffffb, 32'hfffffff9, 0);
        setEntry(3,  "mulW min x -1",       mulOpPkg::mulW,   32'h80000000, 32'hffffffff, 0);
        setEntry(4,  "mulHW neg x pos",     mulOpPkg::mulHW,  32'hfffffffb, 32'h00000003, 0);
        setEntry(5,  "mulHWU neg x pos",    mulOpPkg::mulHWU, 32'hfffffffb, 32'h00000003, 0);
        setEntry(6,  "mulHW min x -1",      mulOpPkg::mulHW,  32'h80000000, 32'hffffffff, 0);
        setEntry(7,  "mulHWU min x -1",     mulOpPkg::mulHWU, 32'h80000000, 32'hffffffff, 3);
        setEntry(8,  "booth all ones lo",   mulOpPkg::mulW,   32'h12345678, 32'hffffffff, 0);
        setEntry(9,  "booth all ones hu",   mulOpPkg::mulHWU, 32'h12345678, 32'hffffffff, 1);
        setEntry(10, "booth all zeros",     mulOpPkg::mulHW,  32'hdeadbeef, 32'h00000000, 0);
        setEntry(11, "booth 0101 signed",   mulOpPkg::mulHW,  32'h9abcdef0, 32'h55555555, 0);
        setEntry(12, "booth 1010 unsigned", mulOpPkg::mulHWU, 32'h9abcdef0, 32'haaaaaaaa, 2);
        setEntry(13, "booth 1010 signed",   mulOpPkg::mulHW,  32'h7fffffff, 32'haaaaaaaa, 0);
        setEntry(14, "max x max unsigned",  mulOpPkg::mulHWU, 32'hffffffff, 32'hffffffff, 0);
        setEntry(15, "booth 0011 pattern",  mulOpPkg::mulW,   32'h33333333, 32'hcccccccc, 1);
    endtask

    // one request on the next rising edge
    task automatic driveEntry(input string name, input mulOpPkg::mulOp_t o,
                              input logic [31:0] a, input logic [31:0] b);
        @(posedge Clk);
        inValid      <= 1'b1;
        op           <= o;
        multiplicand <= a;
        multiplier   <= b;
        expQ.push_back(expectedWord(o, a, b));
        nameQ.push_back(name);
        // ports change after this edge, DUT samples on the next one, two stages follow
        dueQ.push_back(cycle + 3);
    endtask

    task automatic idleCycle();
        @(posedge Clk);
        inValid <= 1'b0;
    endtask

    // outputs sampled mid-cycle, well clear of the edge
    always @(negedge Clk) begin
        if (outValid) begin
            assert (expQ.size() != 0)
            else abortRun("outValid pulse seen with no request in flight");
            assert (cycle == dueQ[0])
            else abortRun($sformatf("result for %s came at cycle %0d instead of cycle %0d",
                                    nameQ[0], cycle, dueQ[0]));
            assert (product == expQ[0])
            else abortRun($sformatf("MISMATCH test=%s expected=%08h actual=%08h",
                                    nameQ[0], expQ[0], product));
            void'(expQ.pop_front());
            void'(nameQ.pop_front());
            void'(dueQ.pop_front());
        end
    end

    // watchdog against a stuck pipeline
    always @(posedge Clk) begin
        if (cycle >= timeoutLimit) begin
            abortRun($sformatf("timeout at cycle %0d, %0d results never arrived",
                               cycle, expQ.size()));
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int          pick;
        int          gapTotal;

        inValid      <= 1'b0;
        op           <= mulOpPkg::mulW;
        multiplicand <= '0;
        multiplier   <= '0;
        rstN         <= 1'b0;
        seed = 32'hcee4;

        loadTable();
        gapTotal = 0;
        for (int i = 0; i < tableLen; i++) begin
            gapTotal = gapTotal + tabGap[i];
        end
        timeoutLimit = tableLen + randCount + resetCycles + gapTotal + 20;

        repeat (resetCycles) @(posedge Clk);
        rstN <= 1'b1;
        idleCycle();

        // directed cases, gaps check that idle cycles stay quiet
        for (int i = 0; i < tableLen; i++) begin
            driveEntry(tabName[i], tabOp[i], tabA[i], tabB[i]);
            repeat (tabGap[i]) idleCycle();
        end

        // back-to-back random mix
        for (int n = 0; n < randCount; n++) begin
            a    = $random(seed);
            b    = $random(seed);
            pick = $unsigned($random(seed)) % 3;
            driveEntry($sformatf("random %0d", n), opFromIndex(pick), a, b);
        end
        idleCycle();

        while (expQ.size() != 0) begin
            @(posedge Clk);
        end
        // a few quiet cycles to catch stray pulses
        repeat (4) @(posedge Clk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
rtl/mulOpPkg.sv
rtl/mulArithPkg.sv
rtl/boothEncoder.sv
rtl/wallaceColumn.sv
rtl/productStage.sv
rtl/mulUnit.sv
bench/mulUnitTb.sv

//--- run.sh
#!/bin/sh
# build and run the multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module mulUnitTb -o mulSim \
    && ./obj_dir/mulSim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
# the log decides the outcome
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
